// File: hdl/video_types_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// pixel and byte types
//////////////////////////////////////////////////

package video_types_pkg;

    // raw camera bus
    typedef logic [7:0] cam_byte_t;  // one half of an rgb565 pixel

    // stored pixel, as held in the frame buffer
    // [15:11] red, [10:5] green, [4:0] blue
    typedef logic [15:0] pixel565_t;

    // colour at the vga port
    // [23:16] red, [15:8] green, [7:0] blue
    typedef logic [23:0] rgb888_t;

endpackage : video_types_pkg

`default_nettype wire

// File: hdl/video_timing_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// raster positions and default 640x480 timing
//////////////////////////////////////////////////

package video_timing_pkg;

    // h or v position, shared by camera and vga side
    typedef logic [9:0] count_t;  // 800 and 525 both fit

    // active picture
    localparam int DEF_H_ACTIVE = 640;
    localparam int DEF_V_ACTIVE = 480;

    // horizontal blanking, in pixel clocks
    localparam int DEF_H_FRONT  = 16;
    localparam int DEF_H_SYNC   = 96;
    localparam int DEF_H_BACK   = 48;

    // vertical blanking, in lines
    localparam int DEF_V_FRONT  = 10;
    localparam int DEF_V_SYNC   = 2;
    localparam int DEF_V_BACK   = 33;

endpackage : video_timing_pkg

`default_nettype wire

// File: hdl/camera_capture.sv
`timescale 1ns/1ns
`default_nettype none

module camera_capture #(
    parameter int H_ACTIVE = video_timing_pkg::DEF_H_ACTIVE,
    parameter int V_ACTIVE = video_timing_pkg::DEF_V_ACTIVE
) (
    input  wire                         camera_pclk,
    input  wire                         arst_n,
    input  wire                         capture_frame,  // single-cycle arm
    input  wire                         camera_vsync,
    input  wire                         camera_href,
    input  wire video_types_pkg::cam_byte_t camera_data,
    output logic                        cam_we,         // one-cycle write strobe
    output video_types_pkg::pixel565_t  cam_pixel,
    output video_timing_pkg::count_t    cam_hcount,
    output video_timing_pkg::count_t    cam_vcount,
    output logic                        done            // end of captured frame
);

    import video_types_pkg::*;
    import video_timing_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARMED,    // waiting for start of next frame
        ST_CAPTURE
    } state_t;

    state_t    state;
    logic      vsync_q;
    logic      href_q;
    logic      vsync_fall;
    logic      vsync_rise;
    logic      href_fall;
    logic      byte_phase;  // 0 expects high byte
    logic      capture_en;
    cam_byte_t hi_byte;     // first byte of the pair

    assign vsync_fall = vsync_q & ~camera_vsync;  // frame starts
    assign vsync_rise = ~vsync_q & camera_vsync;  // frame ends
    assign href_fall  = href_q & ~camera_href;    // line ends
    assign capture_en = (state == ST_CAPTURE);

    //////////////////////////////////////////////////
    // frame arming fsm
    //////////////////////////////////////////////////
    always_ff @(posedge camera_pclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            vsync_q <= 1'b0;
            href_q  <= 1'b0;
            done    <= 1'b0;
        end else begin
            vsync_q <= camera_vsync;
            href_q  <= camera_href;
            done    <= 1'b0;
            case (state)
                ST_IDLE:    if (capture_frame) state <= ST_ARMED;
                ST_ARMED:   if (vsync_fall) state <= ST_CAPTURE;  // mid-frame arm waits here
                ST_CAPTURE: if (vsync_rise) begin
                    state <= ST_IDLE;
                    done  <= 1'b1;
                end
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // byte pairing and position counters
    always_ff @(posedge camera_pclk or negedge arst_n) begin
        if (!arst_n) begin
            cam_we     <= 1'b0;
            byte_phase <= 1'b0;
            cam_hcount <= '0;
            cam_vcount <= '0;
        end else begin
            cam_we <= 1'b0;
            if (!capture_en || !camera_href) begin
                byte_phase <= 1'b0;         // realign at every line
            end else if (!byte_phase) begin
                byte_phase <= 1'b1;
            end else begin
                byte_phase <= 1'b0;
                cam_we     <= 1'b1;         // low byte sampled
            end
            if (state == ST_ARMED && vsync_fall) begin
                cam_hcount <= '0;
                cam_vcount <= '0;
            end else if (capture_en) begin
                if (href_fall) begin         // wins over the last write
                    cam_hcount <= '0;
                    cam_vcount <= (cam_vcount == count_t'(V_ACTIVE - 1)) ? '0
                                  : cam_vcount + count_t'(1);
                end else if (cam_we) begin   // step after the pixel is out
                    cam_hcount <= (cam_hcount == count_t'(H_ACTIVE - 1)) ? '0
                                  : cam_hcount + count_t'(1);
                end
            end
        end
    end

    // pixel assembly from the byte pair
    always_ff @(posedge camera_pclk) begin
        if (capture_en && camera_href) begin
            if (!byte_phase) hi_byte <= camera_data;
            else cam_pixel <= {hi_byte, camera_data};  // high byte first
        end
    end

endmodule : camera_capture

`default_nettype wire

// File: hdl/frame_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_buffer #(
    parameter int H_ACTIVE = video_timing_pkg::DEF_H_ACTIVE,
    parameter int V_ACTIVE = video_timing_pkg::DEF_V_ACTIVE
) (
    input  wire                             clk_vga,
    input  wire                             camera_pclk,
    input  wire                             cam_we,
    input  wire video_types_pkg::pixel565_t cam_pixel,
    input  wire video_timing_pkg::count_t   cam_hcount,
    input  wire video_timing_pkg::count_t   cam_vcount,
    input  wire video_timing_pkg::count_t   vga_hcount,
    input  wire video_timing_pkg::count_t   vga_vcount,
    output video_types_pkg::pixel565_t      read_pixel  // one clk_vga late
);

    import video_types_pkg::*;
    import video_timing_pkg::*;

    localparam int DEPTH  = H_ACTIVE * V_ACTIVE;
    localparam int ADDR_W = $clog2(DEPTH);

    pixel565_t         mem [DEPTH];
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    logic              wr_in_area;

    // row major, v * width + h
    assign wr_addr    = ADDR_W'(cam_vcount * H_ACTIVE + cam_hcount);
    assign rd_addr    = ADDR_W'(vga_vcount * H_ACTIVE + vga_hcount);  // wraps in blanking
    assign wr_in_area = (cam_hcount < H_ACTIVE) && (cam_vcount < V_ACTIVE);

    //////////////////////////////////////////////////
    // camera write port
    //////////////////////////////////////////////////
    always_ff @(posedge camera_pclk) begin
        if (cam_we && wr_in_area) mem[wr_addr] <= cam_pixel;
    end

    // vga read port
    always_ff @(posedge clk_vga) begin
        read_pixel <= mem[rd_addr];
    end

endmodule : frame_buffer

`default_nettype wire

// File: hdl/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = video_timing_pkg::DEF_H_ACTIVE,
    parameter int V_ACTIVE = video_timing_pkg::DEF_V_ACTIVE,
    parameter int H_FRONT  = video_timing_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = video_timing_pkg::DEF_H_SYNC,
    parameter int H_BACK   = video_timing_pkg::DEF_H_BACK,
    parameter int V_FRONT  = video_timing_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = video_timing_pkg::DEF_V_SYNC,
    parameter int V_BACK   = video_timing_pkg::DEF_V_BACK
) (
    input  wire                      clk_50,
    input  wire                      arst_n,
    output video_timing_pkg::count_t vga_hcount,
    output video_timing_pkg::count_t vga_vcount,
    output logic                     raw_hsync,  // active low
    output logic                     raw_vsync,  // active low
    output logic                     raw_blank
);

    import video_timing_pkg::*;

    // raster layout, active area first
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    count_t h_next;
    count_t v_next;
    logic   line_end;
    logic   frame_end;

    //////////////////////////////////////////////////
    // next position
    //////////////////////////////////////////////////
    always_comb begin
        line_end  = (vga_hcount == count_t'(H_TOTAL - 1));
        frame_end = (vga_vcount == count_t'(V_TOTAL - 1));
        h_next    = line_end ? '0 : vga_hcount + count_t'(1);
        v_next    = vga_vcount;
        if (line_end) v_next = frame_end ? '0 : vga_vcount + count_t'(1);
    end

    // counts and flags leave together, decoded from the next position
    always_ff @(posedge clk_50 or negedge arst_n) begin
        if (!arst_n) begin
            vga_hcount <= '0;
            vga_vcount <= '0;
            raw_hsync  <= 1'b1;
            raw_vsync  <= 1'b1;
            raw_blank  <= 1'b0;   // 0,0 is active
        end else begin
            vga_hcount <= h_next;
            vga_vcount <= v_next;
            raw_hsync  <= !((h_next >= count_t'(H_SYNC_START)) &&
                            (h_next <  count_t'(H_SYNC_END)));
            raw_vsync  <= !((v_next >= count_t'(V_SYNC_START)) &&
                            (v_next <  count_t'(V_SYNC_END)));
            raw_blank  <= (h_next >= count_t'(H_ACTIVE)) ||
                          (v_next >= count_t'(V_ACTIVE));  // either axis out
        end
    end

endmodule : vga_timing

`default_nettype wire

// File: hdl/vga_pixel_out.sv
`timescale 1ns/1ns
`default_nettype none

module vga_pixel_out (
    input  wire                             clk_50,
    input  wire                             arst_n,
    input  wire video_types_pkg::pixel565_t read_pixel,  // one cycle behind raw_*
    input  wire                             raw_hsync,
    input  wire                             raw_vsync,
    input  wire                             raw_blank,
    output video_types_pkg::rgb888_t        vga_rgb,
    output logic                            vga_hsync,
    output logic                            vga_vsync,
    output logic                            vga_blank
);

    import video_types_pkg::*;

    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
    rgb888_t    rgb_exp;
    logic [1:0] hsync_d;  // [0] lines up with read_pixel
    logic [1:0] vsync_d;
    logic [1:0] blank_d;

    assign red   = read_pixel[15:11];
    assign green = read_pixel[10:5];
    assign blue  = read_pixel[4:0];

    // lowest field bit fills the new low bits
    assign rgb_exp = {red,   {3{red[0]}},
                      green, {2{green[0]}},
                      blue,  {3{blue[0]}}};

    //////////////////////////////////////////////////
    // output pipe
    //////////////////////////////////////////////////
    always_ff @(posedge clk_50 or negedge arst_n) begin
        if (!arst_n) begin
            hsync_d <= 2'b11;
            vsync_d <= 2'b11;
            blank_d <= 2'b11;   // blanked until filled
            vga_rgb <= '0;
        end else begin
            hsync_d <= {hsync_d[0], raw_hsync};
            vsync_d <= {vsync_d[0], raw_vsync};
            blank_d <= {blank_d[0], raw_blank};
            vga_rgb <= blank_d[0] ? '0 : rgb_exp;  // black outside active area
        end
    end

    assign vga_hsync = hsync_d[1];
    assign vga_vsync = vsync_d[1];
    assign vga_blank = blank_d[1];

endmodule : vga_pixel_out

`default_nettype wire

// File: hdl/camera_full.sv
`timescale 1ns/1ns
`default_nettype none

module camera_full #(
    parameter int H_ACTIVE = video_timing_pkg::DEF_H_ACTIVE,
    parameter int V_ACTIVE = video_timing_pkg::DEF_V_ACTIVE,
    parameter int H_FRONT  = video_timing_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = video_timing_pkg::DEF_H_SYNC,
    parameter int H_BACK   = video_timing_pkg::DEF_H_BACK,
    parameter int V_FRONT  = video_timing_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = video_timing_pkg::DEF_V_SYNC,
    parameter int V_BACK   = video_timing_pkg::DEF_V_BACK
) (
    input  wire                             clk_50,       // vga pixel clock
    input  wire                             camera_pclk,
    input  wire                             arst_n,
    input  wire                             capture_frame,
    input  wire                             camera_href,
    input  wire                             camera_vsync,
    input  wire video_types_pkg::cam_byte_t camera_data,
    output wire                             done,
    output wire video_types_pkg::rgb888_t   vga_rgb,
    output wire                             vga_hsync,
    output wire                             vga_vsync,
    output wire                             vga_blank
);

    import video_types_pkg::*;
    import video_timing_pkg::*;

    // camera domain
    wire            cam_we;
    wire pixel565_t cam_pixel;
    wire count_t    cam_hcount;
    wire count_t    cam_vcount;

    // vga domain
    wire count_t    vga_hcount;
    wire count_t    vga_vcount;
    wire            raw_hsync;
    wire            raw_vsync;
    wire            raw_blank;
    wire pixel565_t read_pixel;

    //////////////////////////////////////////////////
    // camera -> memory -> vga
    //////////////////////////////////////////////////
    camera_capture #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) camera_capture_i (
        .camera_pclk  (camera_pclk),
        .arst_n       (arst_n),
        .capture_frame(capture_frame),
        .camera_vsync (camera_vsync),
        .camera_href  (camera_href),
        .camera_data  (camera_data),
        .cam_we       (cam_we),
        .cam_pixel    (cam_pixel),
        .cam_hcount   (cam_hcount),
        .cam_vcount   (cam_vcount),
        .done         (done)
    );

    frame_buffer #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) frame_buffer_i (
        .clk_vga    (clk_50),
        .camera_pclk(camera_pclk),
        .cam_we     (cam_we),
        .cam_pixel  (cam_pixel),
        .cam_hcount (cam_hcount),
        .cam_vcount (cam_vcount),
        .vga_hcount (vga_hcount),
        .vga_vcount (vga_vcount),
        .read_pixel (read_pixel)
    );

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
        .H_FRONT (H_FRONT),  .H_SYNC  (H_SYNC),  .H_BACK(H_BACK),
        .V_FRONT (V_FRONT),  .V_SYNC  (V_SYNC),  .V_BACK(V_BACK)
    ) vga_timing_i (
        .clk_50    (clk_50),
        .arst_n    (arst_n),
        .vga_hcount(vga_hcount),
        .vga_vcount(vga_vcount),
        .raw_hsync (raw_hsync),
        .raw_vsync (raw_vsync),
        .raw_blank (raw_blank)
    );

    vga_pixel_out vga_pixel_out_i (
        .clk_50    (clk_50),
        .arst_n    (arst_n),
        .read_pixel(read_pixel),
        .raw_hsync (raw_hsync),
        .raw_vsync (raw_vsync),
        .raw_blank (raw_blank),
        .vga_rgb   (vga_rgb),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_blank (vga_blank)
    );

endmodule : camera_full

`default_nettype wire

// File: tests/camera_full_checker.sv
`timescale 1ns/1ns
`default_nettype none

module camera_full_checker #(
    parameter int H_ACTIVE = video_timing_pkg::DEF_H_ACTIVE,
    parameter int V_ACTIVE = video_timing_pkg::DEF_V_ACTIVE,
    parameter int H_SYNC   = video_timing_pkg::DEF_H_SYNC
) (
    input wire                           clk_50,       // tied low when bound to capture
    input wire                           camera_pclk,  // tied low when bound to timing
    input wire                           arst_n,
    input wire video_timing_pkg::count_t vga_hcount,
    input wire video_timing_pkg::count_t vga_vcount,
    input wire                           raw_hsync,
    input wire                           raw_blank,
    input wire                           cam_we,
    input wire                           capture_en,
    input wire                           done
);

    import video_timing_pkg::*;

    int     fail_count = 0;  // failed assertions so far
    count_t hsync_low_len;   // low cycles of the current hsync pulse

    always_ff @(posedge clk_50 or negedge arst_n) begin
        if (!arst_n) hsync_low_len <= '0;
        else if (!raw_hsync) hsync_low_len <= hsync_low_len + count_t'(1);
        else hsync_low_len <= '0;
    end

    //////////////////////////////////////////////////
    // vga raster
    //////////////////////////////////////////////////
    a_hsync_width: assert property (@(posedge clk_50) disable iff (!arst_n)
        $rose(raw_hsync) |-> (hsync_low_len == count_t'(H_SYNC)))
        else begin
            $error("hsync low for %0d cycles, expected %0d", hsync_low_len, H_SYNC);
            fail_count++;
        end

    // blank follows the active area on both axes
    a_blank_area: assert property (@(posedge clk_50) disable iff (!arst_n)
        raw_blank == ((vga_hcount >= H_ACTIVE) || (vga_vcount >= V_ACTIVE)))
        else begin
            $error("blank %b at position %0d,%0d", raw_blank, vga_hcount, vga_vcount);
            fail_count++;
        end

    //////////////////////////////////////////////////
    // camera capture
    //////////////////////////////////////////////////
    a_we_in_frame: assert property (@(posedge camera_pclk) disable iff (!arst_n)
        cam_we |-> $past(capture_en))  // strobe is one cycle after the low byte
        else begin
            $error("cam_we high outside a captured frame");
            fail_count++;
        end

    a_done_pulse: assert property (@(posedge camera_pclk) disable iff (!arst_n)
        done |=> !done)
        else begin
            $error("done longer than one cycle");
            fail_count++;
        end

endmodule : camera_full_checker

bind vga_timing camera_full_checker #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .H_SYNC(H_SYNC)
) timing_checker_i (
    .clk_50     (clk_50),
    .camera_pclk(1'b0),
    .arst_n     (arst_n),
    .vga_hcount (vga_hcount),
    .vga_vcount (vga_vcount),
    .raw_hsync  (raw_hsync),
    .raw_blank  (raw_blank),
    .cam_we     (1'b0),
    .capture_en (1'b0),
    .done       (1'b0)
);

bind camera_capture camera_full_checker #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
) capture_checker_i (
    .clk_50     (1'b0),
    .camera_pclk(camera_pclk),
    .arst_n     (arst_n),
    .vga_hcount ('0),
    .vga_vcount ('0),
    .raw_hsync  (1'b1),
    .raw_blank  (1'b0),
    .cam_we     (cam_we),
    .capture_en (capture_en),
    .done       (done)
);

`default_nettype wire

// File: tests/camera_full_tb.sv
`timescale 1ns/1ns
`default_nettype none

module camera_full_tb;

    import video_types_pkg::*;
    import video_timing_pkg::*;

    // small raster, 16x8 picture
    localparam int H_ACTIVE  = 16;
    localparam int V_ACTIVE  = 8;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 2;
    localparam int H_BACK    = 2;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 1;
    localparam int V_BACK    = 1;
    localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_AT = H_ACTIVE + H_FRONT;  // first low hsync column
    localparam int V_SYNC_AT = V_ACTIVE + V_FRONT;  // first low vsync line
    localparam int NPIX      = H_ACTIVE * V_ACTIVE;

    // camera frame shape, camera_pclk cycles
    localparam int CAM_PRE    = 4;  // vsync high, arm slot
    localparam int CAM_GAP    = 3;  // vsync low before first line
    localparam int CAM_HGAP   = 4;  // href low between lines
    localparam int CAM_POST   = 6;  // vsync high, done lands here
    localparam int CAM_CYCLES = CAM_PRE + CAM_GAP + CAM_POST
                                + V_ACTIVE * (2 * H_ACTIVE + CAM_HGAP);

    localparam int     N_ROWS       = 10;
    localparam longint CAM_FRAME_NS = CAM_CYCLES * 40;
    localparam longint VGA_FRAME_NS = H_TOTAL * V_TOTAL * 20;
    localparam longint WATCHDOG_NS  = 2 * N_ROWS * (CAM_FRAME_NS + 2 * VGA_FRAME_NS);

    typedef enum logic [1:0] {ARM_NONE, ARM_BEFORE, ARM_MID} arm_t;
    typedef enum logic [2:0] {SRC_RANDOM, SRC_POS, SRC_ONES, SRC_ZEROS,
                              SRC_LSB1, SRC_LSB0} src_t;
    typedef struct packed {
        arm_t arm;
        src_t src;
        logic keep;  // 1: previous image stays on screen
    } row_t;

    logic      clk_50;
    logic      camera_pclk;
    logic      arst_n;
    logic      capture_frame;
    logic      camera_href;
    logic      camera_vsync;
    cam_byte_t camera_data;
    wire       done;
    wire rgb888_t vga_rgb;
    wire       vga_hsync;
    wire       vga_vsync;
    wire       vga_blank;

    row_t      rows [N_ROWS];
    pixel565_t sent_img [NPIX];  // last frame put on the camera bus
    pixel565_t ref_img [NPIX];   // what the display should hold
    int        err_count;
    int        check_count;
    int        done_count;       // done pulses since the last row check
    int        row_errs;
    int        assert_fails;

    camera_full #(
        .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
        .H_FRONT (H_FRONT),  .H_SYNC  (H_SYNC),  .H_BACK(H_BACK),
        .V_FRONT (V_FRONT),  .V_SYNC  (V_SYNC),  .V_BACK(V_BACK)
    ) camera_full_i (
        .clk_50       (clk_50),
        .camera_pclk  (camera_pclk),
        .arst_n       (arst_n),
        .capture_frame(capture_frame),
        .camera_href  (camera_href),
        .camera_vsync (camera_vsync),
        .camera_data  (camera_data),
        .done         (done),
        .vga_rgb      (vga_rgb),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_blank    (vga_blank)
    );

    always #10 clk_50 = ~clk_50;            // 20 ns
    always #20 camera_pclk = ~camera_pclk;  // 40 ns, rising edges off the clk_50 ones

    always @(negedge camera_pclk) begin
        if (done === 1'b1) done_count++;
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    // each field widened, its lowest bit fills the new low bits
    function automatic rgb888_t expand565(input pixel565_t p);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
        logic [7:0] r8;
        logic [7:0] g8;
        logic [7:0] b8;
        r  = p[15:11];
        g  = p[10:5];
        b  = p[4:0];
        r8 = {r, 3'b000} | (r[0] ? 8'h07 : 8'h00);
        g8 = {g, 2'b00} | (g[0] ? 8'h03 : 8'h00);
        b8 = {b, 3'b000} | (b[0] ? 8'h07 : 8'h00);
        return {r8, g8, b8};
    endfunction

    function automatic pixel565_t pixel_for(input src_t src, input int h, input int v);
        case (src)
            SRC_RANDOM: return pixel565_t'($urandom);
            SRC_POS:    return {5'(v), 6'(h), 5'(h ^ v)};  // unique per position
            SRC_ONES:   return 16'hffff;
            SRC_ZEROS:  return 16'h0000;
            SRC_LSB1:   return 16'h0821;  // each field 0..01
            default:    return 16'hf7de;  // each field 1..10
        endcase
    endfunction

    // 0 none, 1 exactly one, x for more
    function automatic logic done_seen(input int n);
        return (n == 0) ? 1'b0 : (n == 1) ? 1'b1 : 1'bx;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic compare_rgb(input rgb888_t got, input rgb888_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t ns: %s rgb %06h, expected %06h", $time, what, got, exp);
        end
    endtask

    task automatic compare_sync(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_done(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t ns: %s done seen %b, expected %b", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // camera frame driver
    //////////////////////////////////////////////////
    task automatic send_frame(input arm_t arm, input src_t src);
        pixel565_t pix;
        for (int i = 0; i < CAM_PRE; i++) begin
            @(posedge camera_pclk);
            camera_vsync  <= 1'b1;
            camera_href   <= 1'b0;
            capture_frame <= (arm == ARM_BEFORE) && (i == 1);
        end
        for (int i = 0; i < CAM_GAP; i++) begin
            @(posedge camera_pclk);
            camera_vsync  <= 1'b0;  // frame start
            capture_frame <= 1'b0;
        end
        for (int v = 0; v < V_ACTIVE; v++) begin
            for (int h = 0; h < H_ACTIVE; h++) begin
                pix = pixel_for(src, h, v);
                sent_img[v * H_ACTIVE + h] = pix;
                @(posedge camera_pclk);
                camera_href   <= 1'b1;
                camera_data   <= pix[15:8];  // high byte first
                capture_frame <= (arm == ARM_MID) && (v == V_ACTIVE / 2) && (h == 0);
                @(posedge camera_pclk);
                camera_data   <= pix[7:0];
                capture_frame <= 1'b0;
            end
            for (int i = 0; i < CAM_HGAP; i++) begin
                @(posedge camera_pclk);
                camera_href <= 1'b0;
                camera_data <= 8'h00;
            end
        end
        for (int i = 0; i < CAM_POST; i++) begin
            @(posedge camera_pclk);
            camera_vsync <= 1'b1;  // frame end
        end
    endtask

    //////////////////////////////////////////////////
    // vga scan checker
    //////////////////////////////////////////////////
    task automatic scan_check();
        rgb888_t exp_rgb;
        logic    active;
        string   pos;
        @(negedge clk_50);
        while (vga_vsync !== 1'b0) @(negedge clk_50);
        while (vga_vsync !== 1'b1) @(negedge clk_50);
        while (vga_blank !== 1'b0) @(negedge clk_50);  // back porch over, now at 0,0
        for (int v = 0; v < V_TOTAL; v++) begin
            for (int h = 0; h < H_TOTAL; h++) begin
                active  = (h < H_ACTIVE) && (v < V_ACTIVE);
                exp_rgb = 24'h0;
                if (active) exp_rgb = expand565(ref_img[v * H_ACTIVE + h]);
                pos = $sformatf("position %0d,%0d", h, v);
                compare_rgb(vga_rgb, exp_rgb, pos);
                compare_sync(vga_blank, !active, {pos, " blank"});
                compare_sync(vga_hsync, !((h >= H_SYNC_AT) && (h < H_SYNC_AT + H_SYNC)),
                             {pos, " hsync"});
                compare_sync(vga_vsync, !((v >= V_SYNC_AT) && (v < V_SYNC_AT + V_SYNC)),
                             {pos, " vsync"});
                @(negedge clk_50);
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h2521_8baf));
        clk_50        = 1'b0;
        camera_pclk   = 1'b0;
        arst_n        = 1'b0;
        capture_frame = 1'b0;
        camera_href   = 1'b0;
        camera_vsync  = 1'b1;  // between frames
        camera_data   = 8'h00;
        err_count     = 0;
        check_count   = 0;
        done_count    = 0;

        // arm, pixel source, keep
        rows[0] = '{ARM_BEFORE, SRC_RANDOM, 1'b0};
        rows[1] = '{ARM_BEFORE, SRC_POS,    1'b0};
        rows[2] = '{ARM_NONE,   SRC_RANDOM, 1'b1};  // not armed
        rows[3] = '{ARM_BEFORE, SRC_ONES,   1'b0};
        rows[4] = '{ARM_BEFORE, SRC_ZEROS,  1'b0};
        rows[5] = '{ARM_BEFORE, SRC_LSB1,   1'b0};
        rows[6] = '{ARM_BEFORE, SRC_LSB0,   1'b0};
        rows[7] = '{ARM_MID,    SRC_RANDOM, 1'b1};  // arm lands mid-frame
        rows[8] = '{ARM_NONE,   SRC_RANDOM, 1'b0};  // still armed from row 7
        rows[9] = '{ARM_NONE,   SRC_POS,    1'b1};

        repeat (3) @(posedge clk_50);
        arst_n <= 1'b1;
        repeat (4) @(posedge camera_pclk);

        for (int r = 0; r < N_ROWS; r++) begin
            row_errs = err_count;
            send_frame(rows[r].arm, rows[r].src);
            compare_done(done_seen(done_count), !rows[r].keep, $sformatf("row %0d", r));
            done_count = 0;  // stray pulses during the scan count against the next row
            if (!rows[r].keep) begin
                for (int i = 0; i < NPIX; i++) ref_img[i] = sent_img[i];
            end
            scan_check();
            $display("row %0d: %s %s %s, %0d errors", r, rows[r].arm.name(),
                     rows[r].src.name(), rows[r].keep ? "kept" : "new", err_count - row_errs);
        end

        assert_fails = camera_full_i.vga_timing_i.timing_checker_i.fail_count
                       + camera_full_i.camera_capture_i.capture_checker_i.fail_count;
        $display("rows %0d, checks %0d, errors %0d, assertion failures %0d",
                 N_ROWS, check_count, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : camera_full_tb

`default_nettype wire

// File: camera_full.f
hdl/video_types_pkg.sv
hdl/video_timing_pkg.sv
hdl/camera_capture.sv
hdl/frame_buffer.sv
hdl/vga_timing.sv
hdl/vga_pixel_out.sv
hdl/camera_full.sv
tests/camera_full_checker.sv
tests/camera_full_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the camera_full testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f camera_full.f --top-module camera_full_tb \
    -Mdir "$build_dir" -o camera_full_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# assertion errors are counted by the testbench, so let the run continue past them
"./$build_dir/camera_full_sim" +verilator+error+limit+1000 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$log_file"; then
    exit 1
fi
exit 0
